// File: source/spmv_macros.svh
`ifndef SPMV_MACROS_SVH
`define SPMV_MACROS_SVH

// chain geometry
`define SPMV_NUM_PE     16
`define SPMV_PE_BCAST   8'hff

// host side register file
`define SPMV_AEG_CNT    2
`define SPMV_AEG_IDX_W  18

// data word and chain word fields
`define SPMV_WORD_W     64
`define SPMV_ACC_W      32
`define SPMV_OP_W       8
`define SPMV_PE_ID_W    8
`define SPMV_OPND_W     48
`define SPMV_CNT_W      16

`endif

// File: source/spmv_host_pkg.sv
`include "spmv_macros.svh"

package spmv_host_pkg;

   //**********************************************************
   // dispatch instruction
   //**********************************************************

   typedef enum logic [1:0] {
      CLS_CAEP   = 2'd0,
      CLS_AEG_WR = 2'd1,
      CLS_AEG_RD = 2'd2
   } inst_class_e;

   // upper bits unused by this personality
   typedef struct packed {
      logic [6:0]                 rsvd;
      inst_class_e                cls;
      logic [4:0]                 caep;
      logic [`SPMV_AEG_IDX_W-1:0] aeg_idx;
   } cae_inst_t;

   //**********************************************************
   // exception pair back to host
   //**********************************************************

   // bit 1 is the index error
   typedef struct packed {
      logic err_aegidx;
      logic err_unimpl;
   } cae_exc_t;

endpackage

// File: source/spmv_chain_pkg.sv
`include "spmv_macros.svh"

package spmv_chain_pkg;

   //**********************************************************
   // chain opcodes
   //**********************************************************

   typedef enum logic [`SPMV_OP_W-1:0] {
      OP_NOP    = 8'd0,
      OP_LOAD   = 8'd1,
      OP_ADD    = 8'd2,
      OP_RETURN = 8'd3
   } chain_op_e;

   //**********************************************************
   // chain word with two views of the same 64 bits
   //**********************************************************

   // command as seen by a PE
   typedef struct packed {
      chain_op_e                op;
      logic [`SPMV_PE_ID_W-1:0] pe_id;
      logic [`SPMV_OPND_W-1:0]  operand;
   } chain_cmd_t;

   // gathered result on its way to the collector
   typedef struct packed {
      chain_op_e                op;
      logic [`SPMV_PE_ID_W-1:0] pe_id;
      logic [`SPMV_CNT_W-1:0]   count;
      logic [`SPMV_ACC_W-1:0]   sum;
   } chain_ret_t;

   typedef union packed {
      chain_cmd_t cmd;
      chain_ret_t ret;
   } chain_word_u;

   // one hop of the systolic chain
   typedef struct packed {
      logic        valid;
      chain_word_u word;
   } chain_link_t;

endpackage

// File: source/spmv_dispatch.sv
`timescale 1ns/1ns
`include "spmv_macros.svh"

module spmv_dispatch (
   input  logic                      clk,
   input  logic                      reset_per,
   input  spmv_host_pkg::cae_inst_t  inst_i,
   input  logic [`SPMV_WORD_W-1:0]   data_i,
   input  logic                      inst_vld_i,
   input  logic                      chain_busy_i,
   input  logic [`SPMV_WORD_W-1:0]   result_i,
   output spmv_chain_pkg::chain_link_t link_o,
   output logic                      busy_o,
   output logic [`SPMV_WORD_W-1:0]   ret_data_o,
   output logic                      ret_data_vld_o,
   output spmv_host_pkg::cae_exc_t   exception_o,
   output logic                      idle_o,
   output logic                      stall_o
);
   import spmv_host_pkg::*;
   import spmv_chain_pkg::*;

   localparam int AEG_SEL_W = $clog2(`SPMV_AEG_CNT);

   logic                    aeg_wr;
   logic                    aeg_rd;
   logic                    launch;
   logic                    unimpl;
   logic                    idx_ok;
   logic [AEG_SEL_W-1:0]    aeg_sel;
   logic [`SPMV_WORD_W-1:0] aeg_rd_data;

   logic [`SPMV_WORD_W-1:0] aeg0_q;
   logic [`SPMV_WORD_W-1:0] ret_data_q;
   logic                    ret_vld_q;
   cae_exc_t                exc_q;
   logic                    launch_q;
   chain_word_u             word_q;

   //**********************************************************
   // instruction decode
   //**********************************************************

   always_comb begin
      aeg_wr = 1'b0;
      aeg_rd = 1'b0;
      launch = 1'b0;
      unimpl = 1'b0;
      if (inst_vld_i) begin
         case (inst_i.cls)
            CLS_AEG_WR: aeg_wr = 1'b1;
            CLS_AEG_RD: aeg_rd = 1'b1;
            CLS_CAEP: begin
               // caep 0 is a no-op and caep 1 starts the chain
               launch = inst_i.caep == 5'd1;
               unimpl = inst_i.caep > 5'd1;
            end
            default: unimpl = 1'b1;
         endcase
      end
   end

   assign idx_ok  = inst_i.aeg_idx < `SPMV_AEG_CNT;
   assign aeg_sel = inst_i.aeg_idx[AEG_SEL_W-1:0];

   // AEG1 lives in the collector
   assign aeg_rd_data = (aeg_sel == '0) ? aeg0_q : result_i;

   //**********************************************************
   // AEG0, return path and exceptions
   //**********************************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         aeg0_q    <= '0;
         ret_vld_q <= 1'b0;
         exc_q     <= '0;
         launch_q  <= 1'b0;
      end else begin
         // writes to AEG1 are dropped here
         if (aeg_wr && idx_ok && aeg_sel == '0) begin
            aeg0_q <= data_i;
         end
         ret_vld_q        <= aeg_rd && idx_ok;
         exc_q.err_aegidx <= (aeg_wr || aeg_rd) && !idx_ok;
         exc_q.err_unimpl <= unimpl;
         launch_q         <= launch;
      end
   end

   always_ff @(posedge clk) begin
      if (aeg_rd) begin
         ret_data_q <= aeg_rd_data;
      end
      if (launch) begin
         word_q <= aeg0_q;
      end
   end

   assign ret_data_o     = ret_data_q;
   assign ret_data_vld_o = ret_vld_q;
   assign exception_o    = exc_q;

   //**********************************************************
   // chain launch and busy
   //**********************************************************

   assign link_o.valid = launch_q;
   assign link_o.word  = word_q;

   // decode cycle plus the launch stage
   assign busy_o  = launch || launch_q;
   assign stall_o = busy_o || chain_busy_i;
   assign idle_o  = !stall_o;

   // no new launch until the collector has taken the word in flight
   a_one_in_flight : assert property (@(posedge clk) disable iff (reset_per)
      launch |=> !launch [*(`SPMV_NUM_PE + 1)])
      else $error("caep 1 accepted while stall_o was high");

endmodule

// File: source/spmv_pe.sv
`timescale 1ns/1ns
`include "spmv_macros.svh"

module spmv_pe #(
   parameter int PE_ID = 0
) (
   input  logic                        clk,
   input  logic                        reset_per,
   input  spmv_chain_pkg::chain_link_t link_i,
   input  logic                        busy_i,
   output spmv_chain_pkg::chain_link_t link_o,
   output logic                        busy_o
);
   import spmv_chain_pkg::*;

   logic                   hit;
   logic                   bcast;
   logic [`SPMV_ACC_W-1:0] acc_d;
   logic [`SPMV_ACC_W-1:0] acc_q;
   chain_word_u            word_d;
   chain_word_u            word_q;
   logic                   vld_q;

   assign hit   = link_i.word.cmd.pe_id == `SPMV_PE_ID_W'(PE_ID);
   assign bcast = link_i.word.cmd.pe_id == `SPMV_PE_BCAST;

   // accumulator update and return gathering
   always_comb begin
      acc_d  = acc_q;
      word_d = link_i.word;
      if (link_i.valid) begin
         case (link_i.word.cmd.op)
            OP_LOAD: begin
               if (hit) begin
                  acc_d = link_i.word.cmd.operand[`SPMV_ACC_W-1:0];
               end
            end
            OP_ADD: begin
               if (hit || bcast) begin
                  acc_d = acc_q + link_i.word.cmd.operand[`SPMV_ACC_W-1:0];
               end
            end
            OP_RETURN: begin
               word_d.ret.sum   = link_i.word.ret.sum + acc_q;
               word_d.ret.count = link_i.word.ret.count + 1'b1;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         acc_q <= '0;
         vld_q <= 1'b0;
      end else begin
         acc_q <= acc_d;
         vld_q <= link_i.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (link_i.valid) begin
         word_q <= word_d;
      end
   end

   // one register stage per PE
   assign link_o.valid = vld_q;
   assign link_o.word  = word_q;
   assign busy_o       = busy_i || vld_q;

   a_vld_known : assert property (@(posedge clk) disable iff (reset_per)
      !$isunknown(link_o.valid))
      else $error("PE %0d output valid unknown", PE_ID);

endmodule

// File: source/spmv_collector.sv
`timescale 1ns/1ns
`include "spmv_macros.svh"

module spmv_collector (
   input  logic                        clk,
   input  logic                        reset_per,
   input  spmv_chain_pkg::chain_link_t link_i,
   output logic [`SPMV_WORD_W-1:0]     result_o
);
   import spmv_chain_pkg::*;

   logic                    capture;
   logic [`SPMV_WORD_W-1:0] result_q;

   //**********************************************************
   // chain end and result register AEG1
   //**********************************************************

   // everything but a RETURN just falls off the end
   assign capture = link_i.valid && link_i.word.ret.op == OP_RETURN;

   always_ff @(posedge clk) begin
      if (reset_per) begin
         result_q <= '0;
      end else if (capture) begin
         result_q <= link_i.word;
      end
   end

   assign result_o = result_q;

   // every PE must have added its share on the way down
   a_ret_count : assert property (@(posedge clk) disable iff (reset_per)
      capture |-> link_i.word.ret.count == `SPMV_NUM_PE)
      else $error("RETURN count %0d, expected %0d",
                  link_i.word.ret.count, `SPMV_NUM_PE);

endmodule

// File: source/spmv_pers_top.sv
`timescale 1ns/1ns
`include "spmv_macros.svh"

module spmv_pers_top (
   input  logic                      clk,
   input  logic                      reset_per,
   input  spmv_host_pkg::cae_inst_t  inst_i,
   input  logic [`SPMV_WORD_W-1:0]   data_i,
   input  logic                      inst_vld_i,
   output logic [`SPMV_WORD_W-1:0]   ret_data_o,
   output logic                      ret_data_vld_o,
   output spmv_host_pkg::cae_exc_t   exception_o,
   output logic                      idle_o,
   output logic                      stall_o
);
   import spmv_chain_pkg::*;

   chain_link_t             link [0:`SPMV_NUM_PE];
   logic [`SPMV_NUM_PE:0]   busy;
   logic [`SPMV_WORD_W-1:0] result;

   spmv_dispatch u_dispatch (
      .clk            (clk),
      .reset_per      (reset_per),
      .inst_i         (inst_i),
      .data_i         (data_i),
      .inst_vld_i     (inst_vld_i),
      .chain_busy_i   (busy[`SPMV_NUM_PE]),
      .result_i       (result),
      .link_o         (link[0]),
      .busy_o         (busy[0]),
      .ret_data_o     (ret_data_o),
      .ret_data_vld_o (ret_data_vld_o),
      .exception_o    (exception_o),
      .idle_o         (idle_o),
      .stall_o        (stall_o)
   );

   // systolic chain with busy running alongside
   generate
      for (genvar k = 0; k < `SPMV_NUM_PE; k++) begin : g_pe
         spmv_pe #(
            .PE_ID (k)
         ) u_pe (
            .clk       (clk),
            .reset_per (reset_per),
            .link_i    (link[k]),
            .busy_i    (busy[k]),
            .link_o    (link[k+1]),
            .busy_o    (busy[k+1])
         );
      end
   endgenerate

   spmv_collector u_collector (
      .clk       (clk),
      .reset_per (reset_per),
      .link_i    (link[`SPMV_NUM_PE]),
      .result_o  (result)
   );

endmodule

// File: dv/spmv_pers_tb.sv
`timescale 1ns/1ns
`include "spmv_macros.svh"

module spmv_pers_tb;
   import spmv_host_pkg::*;
   import spmv_chain_pkg::*;

   localparam int IDLE_TIMEOUT = 64;
   localparam int RET_TIMEOUT  = 8;

   typedef enum logic [1:0] {
      K_WR,
      K_RD,
      K_CAEP,
      K_IDLE
   } row_kind_e;

   typedef struct packed {
      row_kind_e               kind;
      cae_inst_t               inst;
      logic [`SPMV_WORD_W-1:0] data;
      logic [`SPMV_WORD_W-1:0] exp_data;
      logic                    exp_vld;
      cae_exc_t                exp_exc;
   } row_t;

   logic                    clk;
   logic                    reset_per;
   cae_inst_t               inst_i;
   logic [`SPMV_WORD_W-1:0] data_i;
   logic                    inst_vld_i;
   logic [`SPMV_WORD_W-1:0] ret_data_o;
   logic                    ret_data_vld_o;
   cae_exc_t                exception_o;
   logic                    idle_o;
   logic                    stall_o;

   row_t  rows[$];
   string names[$];

   // reference model state
   logic [`SPMV_ACC_W-1:0]  model_acc [0:`SPMV_NUM_PE-1];
   logic [`SPMV_WORD_W-1:0] model_aeg0;
   logic [`SPMV_WORD_W-1:0] model_aeg1;

   integer seed;
   int     err_cnt;
   int     tmo_cnt;

   spmv_pers_top u_dut (
      .clk            (clk),
      .reset_per      (reset_per),
      .inst_i         (inst_i),
      .data_i         (data_i),
      .inst_vld_i     (inst_vld_i),
      .ret_data_o     (ret_data_o),
      .ret_data_vld_o (ret_data_vld_o),
      .exception_o    (exception_o),
      .idle_o         (idle_o),
      .stall_o        (stall_o)
   );

   always #4 clk = ~clk;

   //**********************************************************
   // reference model
   //**********************************************************

   function automatic logic [63:0] make_cmd(input chain_op_e op, input logic [7:0] pe,
                                            input logic [31:0] opnd);
      return {op, pe, 16'h0000, opnd};
   endfunction

   // PE rules applied to the whole chain at once
   task automatic model_apply(input logic [63:0] word);
      logic [7:0]  op;
      logic [7:0]  pe;
      logic [31:0] opnd;
      logic [31:0] total;
      logic [15:0] cnt;
      op   = word[63:56];
      pe   = word[55:48];
      opnd = word[31:0];
      case (op)
         OP_LOAD: begin
            if (pe < `SPMV_NUM_PE) model_acc[pe] = opnd;
         end
         OP_ADD: begin
            for (int k = 0; k < `SPMV_NUM_PE; k++) begin
               if (pe == k || pe == `SPMV_PE_BCAST) model_acc[k] = model_acc[k] + opnd;
            end
         end
         OP_RETURN: begin
            total = opnd;
            for (int k = 0; k < `SPMV_NUM_PE; k++) begin
               total = total + model_acc[k];
            end
            cnt        = word[47:32] + `SPMV_NUM_PE;
            model_aeg1 = {word[63:48], cnt, total};
         end
         default: ;
      endcase
   endtask

   //**********************************************************
   // stimulus table
   //**********************************************************

   task automatic add_row(input string name, input row_kind_e kind, input logic [4:0] caep,
                          input logic [17:0] idx, input logic [63:0] data);
      row_t r;
      r          = '0;
      r.kind     = kind;
      r.data     = data;
      r.inst.caep    = caep;
      r.inst.aeg_idx = idx;
      case (kind)
         K_WR: begin
            r.inst.cls = CLS_AEG_WR;
            if (idx >= `SPMV_AEG_CNT) r.exp_exc = 2'b10;
            else if (idx == 0) model_aeg0 = data;
         end
         K_RD: begin
            r.inst.cls = CLS_AEG_RD;
            if (idx >= `SPMV_AEG_CNT) begin
               r.exp_exc = 2'b10;
            end else begin
               r.exp_vld  = 1'b1;
               r.exp_data = (idx == 0) ? model_aeg0 : model_aeg1;
            end
         end
         K_CAEP: begin
            r.inst.cls = CLS_CAEP;
            if (caep == 5'd1) model_apply(model_aeg0);
            else if (caep != 5'd0) r.exp_exc = 2'b01;
         end
         default: ;
      endcase
      rows.push_back(r);
      names.push_back(name);
   endtask

   // one custom command loads AEG0, launches and waits for the chain to drain
   task automatic add_custom(input string name, input logic [63:0] cmd);
      add_row({name, " wr aeg0"}, K_WR, 5'd0, 18'd0, cmd);
      add_row({name, " caep1"}, K_CAEP, 5'd1, 18'd0, '0);
      add_row({name, " idle"}, K_IDLE, 5'd0, 18'd0, '0);
   endtask

   task automatic build_table();
      logic [63:0] rnd;
      logic [31:0] opnd;
      for (int k = 0; k < `SPMV_NUM_PE; k++) model_acc[k] = '0;
      model_aeg0 = '0;
      model_aeg1 = '0;

      add_row("rd aeg1 after reset", K_RD, 5'd0, 18'd1, '0);
      rnd = {$random(seed), $random(seed)};
      add_row("wr aeg0", K_WR, 5'd0, 18'd0, rnd);
      add_row("rd aeg0", K_RD, 5'd0, 18'd0, '0);
      add_row("wr bad idx", K_WR, 5'd0, 18'd2, rnd);
      add_row("rd bad idx", K_RD, 5'd0, 18'h3ffff, '0);
      add_row("caep 5", K_CAEP, 5'd5, 18'd0, '0);
      add_row("caep 0", K_CAEP, 5'd0, 18'd0, '0);

      for (int k = 0; k < `SPMV_NUM_PE; k++) begin
         opnd = $random(seed);
         add_custom($sformatf("load pe %0d", k), make_cmd(OP_LOAD, k[7:0], opnd));
      end
      opnd = $random(seed);
      add_custom("bcast add", make_cmd(OP_ADD, `SPMV_PE_BCAST, opnd));
      add_custom("return 1", make_cmd(OP_RETURN, 8'h00, 32'h0));
      add_row("rd sum 1", K_RD, 5'd0, 18'd1, '0);

      // single PE add must move the sum by exactly its operand
      opnd = $random(seed);
      add_custom("add pe 7", make_cmd(OP_ADD, 8'd7, opnd));
      add_custom("return 2", make_cmd(OP_RETURN, 8'h00, 32'h0));
      add_row("rd sum 2", K_RD, 5'd0, 18'd1, '0);

      rnd = {$random(seed), $random(seed)};
      add_row("wr aeg1", K_WR, 5'd0, 18'd1, rnd);
      add_row("rd aeg1 after wr", K_RD, 5'd0, 18'd1, '0);
      add_row("rd aeg0 final", K_RD, 5'd0, 18'd0, '0);
   endtask

   //**********************************************************
   // checks and waits
   //**********************************************************

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
      assert (got === exp)
      else begin
         $display("ERROR %s: expected %h, actual %h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic wait_idle(input string name);
      int cyc;
      cyc = 0;
      while (!idle_o && cyc < IDLE_TIMEOUT) begin
         @(negedge clk);
         cyc++;
      end
      if (!idle_o) begin
         $display("timeout: idle_o stayed low for %0d cycles at %s", IDLE_TIMEOUT, name);
         tmo_cnt++;
      end
   endtask

   task automatic wait_ret(input string name, output int cyc);
      cyc = 0;
      while (!ret_data_vld_o && cyc < RET_TIMEOUT) begin
         @(negedge clk);
         cyc++;
      end
      if (!ret_data_vld_o) begin
         $display("timeout: ret_data_vld_o never rose for %s", name);
         tmo_cnt++;
      end
   endtask

   // starts and ends on a falling edge
   task automatic apply_row(input row_t r, input string name);
      int cyc;
      if (r.kind == K_IDLE) begin
         wait_idle(name);
      end else begin
         inst_i     = r.inst;
         data_i     = r.data;
         inst_vld_i = 1'b1;
         @(negedge clk);
         inst_vld_i = 1'b0;
         inst_i     = '0;
         data_i     = '0;
         check_val({name, " exception"}, r.exp_exc, exception_o);
         if (r.kind == K_CAEP && r.inst.caep == 5'd1) begin
            check_val({name, " stall"}, 1, stall_o);
            check_val({name, " idle"}, 0, idle_o);
         end
         if (r.exp_vld) begin
            wait_ret(name, cyc);
            if (ret_data_vld_o) begin
               check_val({name, " latency"}, 0, cyc);
               check_val({name, " data"}, r.exp_data, ret_data_o);
            end
         end else begin
            check_val({name, " ret valid"}, 0, ret_data_vld_o);
         end
      end
   endtask

   //**********************************************************
   // main sequence
   //**********************************************************

   initial begin
      clk        = 1'b0;
      reset_per  = 1'b1;
      inst_i     = '0;
      data_i     = '0;
      inst_vld_i = 1'b0;
      seed       = 32'hb01a_b672;
      err_cnt    = 0;
      tmo_cnt    = 0;

      build_table();

      repeat (3) @(negedge clk);
      reset_per = 1'b0;

      check_val("reset idle", 1, idle_o);
      check_val("reset stall", 0, stall_o);
      check_val("reset ret valid", 0, ret_data_vld_o);
      check_val("reset exception", 0, exception_o);

      // a timeout stops the table
      for (int i = 0; i < rows.size() && tmo_cnt == 0; i++) begin
         apply_row(rows[i], names[i]);
      end

      $display("errors: %0d value, %0d timeout", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: spmv_pers.f
+incdir+source
source/spmv_host_pkg.sv
source/spmv_chain_pkg.sv
source/spmv_dispatch.sv
source/spmv_pe.sv
source/spmv_collector.sv
source/spmv_pers_top.sv
dv/spmv_pers_tb.sv
